// File: src.f
hdl/uart_cfg_pkg.sv
hdl/uart_frame_pkg.sv
hdl/uart_baud_gen.sv
hdl/uart_cmd_tx.sv
hdl/uart_rx.sv
hdl/uart.sv
verification/uart_tb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module uart_tb -f src.f -o uart_sim \
  && ./obj_dir/uart_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "test passed" sim.log && exit 0 || exit 1

// File: verification/uart_tb.sv
`timescale 1ns/1ns

module uart_tb;

  localparam int bit_cycles = uart_cfg_pkg::tick_div * uart_cfg_pkg::os_rate;

  typedef struct {
    string                      name;
    bit                         is_rx;
    logic [15:0]                word;
    logic                       par_bad;
    logic                       stop;
    uart_frame_pkg::cmd_t       exp_cmd;
    uart_frame_pkg::rx_result_t exp_rx;
  } test_t;

  logic                       clk;
  logic                       rst_n;
  uart_frame_pkg::cmd_t       cmd;
  logic                       cmd_vld;
  logic                       cmd_rdy;
  logic                       rx;
  logic                       tx;
  logic                       read_rdy;
  uart_frame_pkg::rx_result_t read_data;

  test_t                      tests[$];
  uart_frame_pkg::rx_result_t rx_q[$];
  integer                     seed;
  int                         limit;
  int                         cycles;
  int                         accept_cnt;
  int                         sent_cmds;
  int                         pass_cnt;
  int                         fail_cnt;
  bit                         test_ok;

  uart u_uart (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: the run did not finish within %0d clock cycles", limit);
      $display("test failed");
      $finish;
    end
  end

  // both sampled mid-cycle, away from the clock edge
  always @(negedge clk) begin
    if (rst_n && cmd_vld && cmd_rdy) begin
      accept_cnt <= accept_cnt + 1;
    end
    if (read_rdy) begin
      rx_q.push_back(read_data);
    end
  end

  // data plus parity must hold an odd number of ones
  function automatic logic odd_parity(input logic [7:0] data);
    return !(^data);
  endfunction

  task automatic add_cmd(input string name, input logic [15:0] word);
    test_t t;
    t.name = name;
    t.is_rx = 1'b0;
    t.word = word;
    t.par_bad = 1'b0;
    t.stop = 1'b1;
    t.exp_cmd.hi_byte = word[15:8];
    t.exp_cmd.lo_byte = word[7:0];
    t.exp_rx = '0;
    tests.push_back(t);
  endtask

  task automatic add_rx(input string name, input logic [7:0] data, input logic par_bad,
                        input logic stop);
    test_t t;
    t.name = name;
    t.is_rx = 1'b1;
    t.word = {8'h00, data};
    t.par_bad = par_bad;
    t.stop = stop;
    t.exp_cmd = '0;
    t.exp_rx.data = data;
    t.exp_rx.parity_err = par_bad;
    t.exp_rx.frame_err = !stop;
    tests.push_back(t);
  endtask

  task automatic build_table();
    integer rnd;
    add_cmd("cmd_a55a", 16'ha55a);
    // next two are held on cmd while the line is busy
    add_cmd("cmd_0001", 16'h0001);
    add_cmd("cmd_ff00", 16'hff00);
    add_rx("rx_good_3c", 8'h3c, 1'b0, 1'b1);
    rnd = $random(seed);
    add_rx("rx_rand_0", rnd[7:0], 1'b0, 1'b1);
    rnd = $random(seed);
    add_rx("rx_rand_1", rnd[7:0], 1'b0, 1'b1);
    add_rx("rx_parity_a7", 8'ha7, 1'b1, 1'b1);
    add_rx("rx_frame_5e", 8'h5e, 1'b0, 1'b0);
    add_rx("rx_after_81", 8'h81, 1'b0, 1'b1);
  endtask

  task automatic flag_error(input string msg);
    $display("ERROR: %s", msg);
    test_ok = 1'b0;
  endtask

  task automatic check_cmd(input string name, input uart_frame_pkg::cmd_t exp,
                           input uart_frame_pkg::cmd_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, got %h", name, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_rx(input string name, input uart_frame_pkg::rx_result_t exp,
                          input uart_frame_pkg::rx_result_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, got %h", name, exp, act);
      test_ok = 1'b0;
    end
  endtask

  // bit 0 is the start bit, bit 10 the stop bit
  task automatic read_tx_frame(output logic [10:0] bits);
    int i;
    @(negedge tx);
    repeat (bit_cycles / 2) @(posedge clk);
    #1;
    for (i = 0; i < 11; i++) begin
      bits[i] = tx;
      if (i < 10) begin
        repeat (bit_cycles) @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic check_tx_frame(input string name, input logic [10:0] bits);
    if (bits[0] !== 1'b0 || bits[10] !== 1'b1) begin
      flag_error($sformatf("%s: tx frame has a bad start or stop bit", name));
    end
    if (^bits[9:1] !== 1'b1) begin
      flag_error($sformatf("%s: tx frame parity is not odd", name));
    end
  endtask

  task automatic run_cmd_test(input int idx);
    logic [10:0]          hi_bits;
    logic [10:0]          lo_bits;
    int                   guard;
    uart_frame_pkg::cmd_t got;
    if (!cmd_vld) begin
      cmd = tests[idx].word;
      cmd_vld = 1'b1;
    end
    while (!cmd_rdy) @(negedge clk);
    @(posedge clk);
    #2;
    sent_cmds++;
    if (accept_cnt != sent_cmds) begin
      flag_error($sformatf("%s: %0d commands accepted, %0d expected", tests[idx].name,
                           accept_cnt, sent_cmds));
    end
    // hold the next command to exercise back-pressure
    if (idx + 1 < tests.size() && !tests[idx + 1].is_rx) begin
      cmd = tests[idx + 1].word;
    end else begin
      cmd_vld = 1'b0;
    end
    read_tx_frame(hi_bits);
    read_tx_frame(lo_bits);
    check_tx_frame(tests[idx].name, hi_bits);
    check_tx_frame(tests[idx].name, lo_bits);
    if (cmd_rdy !== 1'b0 || accept_cnt != sent_cmds) begin
      flag_error($sformatf("%s: a command was taken before the low-byte stop bit ended",
                           tests[idx].name));
    end
    got.hi_byte = hi_bits[8:1];
    got.lo_byte = lo_bits[8:1];
    check_cmd(tests[idx].name, tests[idx].exp_cmd, got);
    // ready is due when the low-byte stop bit ends, half a bit from here
    guard = 0;
    while (!cmd_rdy && guard < bit_cycles) begin
      @(negedge clk);
      guard++;
    end
    if (!cmd_rdy) begin
      flag_error($sformatf("%s: cmd_rdy did not return after the low-byte stop bit",
                           tests[idx].name));
    end
  endtask

  task automatic run_rx_test(input int idx);
    logic [10:0]                bits;
    int                         i;
    int                         guard;
    uart_frame_pkg::rx_result_t got;
    bits = {tests[idx].stop, odd_parity(tests[idx].word[7:0]) ^ tests[idx].par_bad,
            tests[idx].word[7:0], 1'b0};
    @(posedge clk);
    #2;
    for (i = 0; i < 11; i++) begin
      rx = bits[i];
      repeat (bit_cycles) @(posedge clk);
      #2;
    end
    // one idle bit so the next start bit is a clean falling edge
    rx = 1'b1;
    repeat (bit_cycles) @(posedge clk);
    #2;
    guard = 0;
    while (rx_q.size() == 0 && guard < bit_cycles) begin
      @(negedge clk);
      guard++;
    end
    if (rx_q.size() != 1) begin
      flag_error($sformatf("%s: expected one read_rdy pulse, saw %0d", tests[idx].name,
                           rx_q.size()));
      rx_q.delete();
    end else begin
      got = rx_q.pop_front();
      check_rx(tests[idx].name, tests[idx].exp_rx, got);
    end
  endtask

  task automatic finish_test(input string name);
    if (test_ok) begin
      pass_cnt++;
      $display("%-14s ok", name);
    end else begin
      fail_cnt++;
      $display("%-14s failed", name);
    end
  endtask

  initial begin
    int idx;
    seed = 32'hbdb1;
    rst_n = 1'b0;
    cmd = '0;
    cmd_vld = 1'b0;
    rx = 1'b1;
    cycles = 0;
    accept_cnt = 0;
    sent_cmds = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    limit = 0;
    build_table();
    limit = tests.size() * 12000 + 2000;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    test_ok = 1'b1;
    if (tx !== 1'b1 || cmd_rdy !== 1'b1 || read_rdy !== 1'b0) begin
      flag_error("tx, cmd_rdy or read_rdy not at the idle level after reset");
    end
    finish_test("reset_state");
    for (idx = 0; idx < tests.size(); idx++) begin
      test_ok = 1'b1;
      if (tests[idx].is_rx) begin
        run_rx_test(idx);
      end else begin
        run_cmd_test(idx);
      end
      finish_test(tests[idx].name);
    end
    $display("passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: hdl/uart.sv
`timescale 1ns/1ns

module uart #(
  parameter bit check_parity = 1'b1
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  uart_frame_pkg::cmd_t       cmd,
  input  logic                       cmd_vld,
  output logic                       cmd_rdy,
  input  logic                       rx,
  output logic                       tx,
  output logic                       read_rdy,
  output uart_frame_pkg::rx_result_t read_data
);

  logic os_tick;

  uart_baud_gen u_baud_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .os_tick (os_tick)
  );

  uart_cmd_tx u_cmd_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .os_tick (os_tick),
    .cmd     (cmd),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .tx      (tx)
  );

  uart_rx #(
    .check_parity (check_parity)
  ) u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .os_tick   (os_tick),
    .rx        (rx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

endmodule

// File: hdl/uart_rx.sv
`timescale 1ns/1ns

module uart_rx #(
  parameter bit check_parity = 1'b1
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       os_tick,
  input  logic                       rx,
  output logic                       read_rdy,
  output uart_frame_pkg::rx_result_t read_data
);

  logic                               rx_meta;
  logic                               rx_sync;
  logic                               rx_prev;
  logic                               rx_fall;
  logic                               busy;
  logic [uart_cfg_pkg::os_cnt_w-1:0]  os_cnt;
  logic [uart_cfg_pkg::bit_cnt_w-1:0] bit_cnt;
  logic                               sample;
  logic                               bit_end;
  logic                               last_bit;
  logic                               start_glitch;
  uart_frame_pkg::frame_u             frame;
  uart_frame_pkg::frame_u             frame_nxt;
  uart_frame_pkg::rx_result_t         result;

  // two-stage sync plus one more flop for the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign rx_fall  = rx_prev && !rx_sync;
  assign sample   = busy && os_tick && (int'(os_cnt) == uart_cfg_pkg::os_rate / 2 - 1);
  assign bit_end  = busy && os_tick && (int'(os_cnt) == uart_cfg_pkg::os_rate - 1);
  assign last_bit = (int'(bit_cnt) == uart_cfg_pkg::frame_bits - 1);

  // start bit already high again at mid-bit
  assign start_glitch = sample && (bit_cnt == '0) && rx_sync;

  // new bit enters at the top, start bit ends up in bit 0
  assign frame_nxt.raw = {rx_sync, frame.raw[uart_cfg_pkg::frame_bits-1:1]};

  assign result.data       = frame_nxt.fields.data;
  assign result.parity_err = check_parity
                             && !(^{frame_nxt.fields.data, frame_nxt.fields.parity});
  assign result.frame_err  = !frame_nxt.fields.stop;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      os_cnt  <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      if (rx_fall) begin
        busy    <= 1'b1;
        os_cnt  <= '0;
        bit_cnt <= '0;
      end
    end else if (start_glitch) begin
      busy <= 1'b0;
    end else if (sample && last_bit) begin
      // free again in mid stop bit, ready for the next edge
      busy <= 1'b0;
    end else if (bit_end) begin
      os_cnt  <= '0;
      bit_cnt <= bit_cnt + 1'b1;
    end else if (os_tick) begin
      os_cnt <= os_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (sample) begin
      frame <= frame_nxt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_rdy <= 1'b0;
    end else begin
      read_rdy <= sample && last_bit;
    end
  end

  // held until the next frame completes
  always_ff @(posedge clk) begin
    if (sample && last_bit) begin
      read_data <= result;
    end
  end

  a_rdy_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy
  );

endmodule

// File: hdl/uart_cmd_tx.sv
`timescale 1ns/1ns

module uart_cmd_tx (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 os_tick,
  input  uart_frame_pkg::cmd_t cmd,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic                 tx
);

  uart_frame_pkg::cmd_t                cmd_q;
  uart_frame_pkg::frame_u              frame;
  logic                                busy;
  logic                                on_line;
  logic                                sel_lo;
  logic [uart_cfg_pkg::os_cnt_w-1:0]   os_cnt;
  logic [uart_cfg_pkg::bit_cnt_w-1:0]  bit_cnt;
  logic                                accept;
  logic                                bit_end;
  logic                                frame_end;

  // start low, odd parity over data, stop high
  function automatic uart_frame_pkg::frame_u build_frame(
    input logic [uart_cfg_pkg::byte_width-1:0] data
  );
    uart_frame_pkg::frame_u f;
    f.fields.start  = 1'b0;
    f.fields.data   = data;
    f.fields.parity = ~^data;
    f.fields.stop   = 1'b1;
    return f;
  endfunction

  assign accept    = cmd_vld && cmd_rdy;
  assign bit_end   = on_line && os_tick && (int'(os_cnt) == uart_cfg_pkg::os_rate - 1);
  assign frame_end = bit_end && (int'(bit_cnt) == uart_cfg_pkg::frame_bits - 1);

  assign cmd_rdy = !busy;
  assign tx      = on_line ? frame.raw[0] : 1'b1;

  // command and frame payload
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
      frame <= build_frame(cmd.hi_byte);
    end else if (frame_end && !sel_lo) begin
      frame <= build_frame(cmd_q.lo_byte);
    end else if (bit_end) begin
      frame.raw <= {1'b1, frame.raw[uart_cfg_pkg::frame_bits-1:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      on_line <= 1'b0;
      sel_lo  <= 1'b0;
      os_cnt  <= '0;
      bit_cnt <= '0;
    end else if (accept) begin
      busy   <= 1'b1;
      sel_lo <= 1'b0;
    end else if (busy && !on_line && os_tick) begin
      // first tick after acceptance opens the high-byte start bit
      on_line <= 1'b1;
      os_cnt  <= '0;
      bit_cnt <= '0;
    end else if (frame_end) begin
      os_cnt  <= '0;
      bit_cnt <= '0;
      if (sel_lo) begin
        busy    <= 1'b0;
        on_line <= 1'b0;
        sel_lo  <= 1'b0;
      end else begin
        // low byte follows straight on
        sel_lo <= 1'b1;
      end
    end else if (bit_end) begin
      os_cnt  <= '0;
      bit_cnt <= bit_cnt + 1'b1;
    end else if (on_line && os_tick) begin
      os_cnt <= os_cnt + 1'b1;
    end
  end

  // line idles high whenever a new command can be taken
  a_idle_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx
  );

  // ready only comes back at the end of the low-byte stop bit
  a_rdy_after_stop: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(cmd_rdy) |-> $past(frame_end && sel_lo)
  );

endmodule

// File: hdl/uart_baud_gen.sv
`timescale 1ns/1ns

module uart_baud_gen (
  input  logic clk,
  input  logic rst_n,
  output logic os_tick
);

  logic [uart_cfg_pkg::tick_cnt_w-1:0] div_cnt;
  logic                                div_wrap;

  assign div_wrap = (int'(div_cnt) == uart_cfg_pkg::tick_div - 1);

  // free running, shared by both directions
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (div_wrap) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // one clock wide pulse per wrap
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      os_tick <= 1'b0;
    end else begin
      os_tick <= div_wrap;
    end
  end

endmodule

// File: hdl/uart_frame_pkg.sv
package uart_frame_pkg;

  // high byte goes out first
  typedef struct packed {
    logic [uart_cfg_pkg::cmd_width-uart_cfg_pkg::byte_width-1:0] hi_byte;
    logic [uart_cfg_pkg::byte_width-1:0]                         lo_byte;
  } cmd_t;

  // bit 0 is the first bit on the line
  typedef struct packed {
    logic                                stop;
    logic                                parity;
    logic [uart_cfg_pkg::byte_width-1:0] data;
    logic                                start;
  } frame_fields_t;

  // tx shifts raw, rx reads fields
  typedef union packed {
    logic [uart_cfg_pkg::frame_bits-1:0] raw;
    frame_fields_t                       fields;
  } frame_u;

  typedef struct packed {
    logic                                frame_err;
    logic                                parity_err;
    logic [uart_cfg_pkg::byte_width-1:0] data;
  } rx_result_t;

endpackage

// File: hdl/uart_cfg_pkg.sv
package uart_cfg_pkg;

  // system clock and line rate
  localparam int clk_hz = 50_000_000;
  localparam int baud = 115_200;
  localparam int os_rate = 16;

  // 50e6 / (115200 * 16) truncates to 27
  localparam int tick_div = clk_hz / (baud * os_rate);

  localparam int cmd_width = 16;
  localparam int byte_width = 8;
  localparam int frame_bits = 11;

  // counter widths
  localparam int tick_cnt_w = $clog2(tick_div);
  localparam int os_cnt_w = $clog2(os_rate);
  localparam int bit_cnt_w = $clog2(frame_bits);

endpackage
